// ==== alu_exec.f ====
source/alu_pkg.sv
source/op_issue.sv
source/op_buffer.sv
source/div_unit.sv
source/alu_core.sv
source/alu_exec_top.sv
sim/alu_checker.sv
sim/tb_alu_exec.sv

// ==== Makefile ====
# Verilator build and run of the ALU subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_alu_exec
FLIST     ?= alu_exec.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary -j 0
PASS_MSG  ?= TEST RESULT: PASS

SOURCES := $(shell grep -v '^+' $(FLIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== sim/alu_testdata.txt ====
// opcode src1 src2 expected_res expected_zero expected_less (hex)
// opcodes: 00 add .. 09 sltu, 0a-0d multiplies, 0e div 0f divu 10 rem 11 remu
00 12345678 11111111 23456789 0 0
01 00000005 00000005 00000000 1 0
01 00000003 00000005 fffffffe 0 0
02 f0f0f0f0 ff00ff00 0ff00ff0 0 0
03 f0f0f0f0 0f0f0000 fffff0f0 0 0
04 f0f0f0f0 ff00ff00 f000f000 0 0
05 00000001 00000024 00000010 0 0
06 80000000 0000001f 00000001 0 0
07 80000000 00000021 c0000000 0 0
07 7ffffff0 00000004 07ffffff 0 0
08 ffffffff 00000001 00000001 0 1
09 ffffffff 00000001 00000000 0 0
09 00000001 00000002 00000001 0 1
0a 00012345 00006789 75cca2ed 0 0
0a fffffffe 00000003 fffffffa 0 0
0b fffffffe 00000003 ffffffff 0 0
0c fffffffe 00000003 00000002 0 0
0d ffffffff 00000002 ffffffff 0 0
0b 80000000 80000000 40000000 0 0
0d 80000000 80000000 c0000000 0 0
0e fffffff9 00000002 fffffffd 0 0
10 fffffff9 00000002 ffffffff 0 0
0f fffffff9 00000002 7ffffffc 0 0
11 fffffff9 00000002 00000001 0 0
0e 00000064 00000000 ffffffff 0 0
10 ffffff00 00000000 ffffff00 0 0
0f 12345678 00000000 ffffffff 0 0
11 12345678 00000000 12345678 0 0
0e 80000000 ffffffff 80000000 0 0
10 80000000 ffffffff 00000000 0 0
10 00000007 fffffffe 00000001 0 0
01 80000000 00000001 7fffffff 0 0

// ==== sim/tb_alu_exec.sv ====
// ------------------
// Testbench top with clock, reset and DUT
// Stimulus from the data file, results to the checker
// ------------------
`timescale 1ns/1ps

module tb_alu_exec;
    import alu_pkg::*;

    localparam int MAX_OPS       = 64;
    localparam int COLS          = 6;
    localparam int READY_TIMEOUT = 200;
    localparam int DRAIN_TIMEOUT = 2000;

    logic                 clk = 1'b0;
    logic                 rst_n;
    logic                 op_valid;
    alu_op_e              op;
    logic [CPU_WIDTH-1:0] src1;
    logic [CPU_WIDTH-1:0] src2;
    logic                 op_ready;
    logic                 res_valid;
    logic [CPU_WIDTH-1:0] res;
    logic                 zero;
    logic                 less;

    logic [31:0] vectors [MAX_OPS*COLS];
    int          num_ops;
    int          other_errors;
    logic        timed_out;
    integer      seed;
    int          mismatches;
    int          checker_errors;
    int          results;
    logic        ready_low_seen;

    always #2 clk = ~clk;

    alu_exec_top dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .op_valid_i  (op_valid),
        .op_i        (op),
        .src1_i      (src1),
        .src2_i      (src2),
        .op_ready_o  (op_ready),
        .res_valid_o (res_valid),
        .res_o       (res),
        .zero_o      (zero),
        .less_o      (less)
    );

    alu_checker u_checker (
        .clk              (clk),
        .rst_n            (rst_n),
        .op_valid_i       (op_valid),
        .op_i             (op),
        .op_ready_i       (op_ready),
        .res_valid_i      (res_valid),
        .res_i            (res),
        .zero_i           (zero),
        .less_i           (less),
        .mismatch_count_o (mismatches),
        .error_count_o    (checker_errors),
        .result_count_o   (results),
        .ready_low_seen_o (ready_low_seen)
    );

    task automatic load_vectors();
        for (int i = 0; i < MAX_OPS*COLS; i++) begin
            vectors[i] = 32'hffff_ffff;
        end
        $readmemh("sim/alu_testdata.txt", vectors);
        num_ops = 0;
        while (num_ops < MAX_OPS && vectors[num_ops*COLS] != 32'hffff_ffff) begin
            num_ops++;
        end
        if (num_ops == 0) begin
            other_errors++;
            $display("No operations found in sim/alu_testdata.txt");
        end
    endtask

    function automatic logic is_divide(input int idx);
        alu_op_e code;
        code = alu_op_e'(vectors[idx*COLS][ALU_OP_WIDTH-1:0]);
        return code inside {ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU};
    endfunction

    // Starts on a falling edge and returns on the one after acceptance
    task automatic issue_op(input int idx, output logic ok);
        int waited;
        op_valid = 1'b1;
        op       = alu_op_e'(vectors[idx*COLS][ALU_OP_WIDTH-1:0]);
        src1     = vectors[idx*COLS+1];
        src2     = vectors[idx*COLS+2];
        waited   = 0;
        // Ready holds its value until the next rising edge
        while (!op_ready && waited < READY_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        ok = op_ready;
        if (ok) begin
            @(negedge clk);
        end else begin
            $display("op_ready_o stayed low for %0d cycles at operation %0d", waited, idx);
        end
    endtask

    task automatic wait_for_results();
        int waited;
        waited = 0;
        while (results < num_ops && waited < DRAIN_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (results < num_ops) begin
            timed_out = 1'b1;
            $display("Timed out waiting for results, got %0d of %0d", results, num_ops);
        end
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        int   gap;
        logic ok;
        rst_n        = 1'b0;
        op_valid     = 1'b0;
        op           = ALU_ADD;
        src1         = '0;
        src2         = '0;
        seed         = 32'hf150;
        other_errors = 0;
        timed_out    = 1'b0;
        load_vectors();

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        if (res_valid !== 1'b0 || op_ready !== 1'b1) begin
            other_errors++;
            $display("After reset res_valid_o is %b and op_ready_o is %b", res_valid, op_ready);
        end

        for (int i = 0; i < num_ops && !timed_out; i++) begin
            // Divides go back to back to run the credits dry
            if (!is_divide(i)) begin
                gap = $unsigned($random(seed)) % 4;
                if (gap > 0) begin
                    op_valid = 1'b0;
                    repeat (gap) @(negedge clk);
                end
            end
            issue_op(i, ok);
            if (!ok) begin
                timed_out = 1'b1;
            end
        end
        op_valid = 1'b0;

        if (!timed_out) begin
            wait_for_results();
            repeat (8) @(negedge clk);
        end
        if (!timed_out && !ready_low_seen) begin
            other_errors++;
            $display("op_ready_o never went low during the divide burst");
        end

        $display("Errors: %0d mismatches, %0d checker errors, %0d other, %0d of %0d results",
                 mismatches, checker_errors, other_errors, results, num_ops);
        if (timed_out || mismatches != 0 || checker_errors != 0 || other_errors != 0 ||
            results != num_ops) begin
            $display("TEST RESULT: FAIL");
        end else begin
            $display("TEST RESULT: PASS");
        end
        $finish;
    end

endmodule

// ==== sim/alu_checker.sv ====
// ------------------
// Result checker of the ALU subsystem
// Compares each result with the next expected line
// Tracks operations in flight and credit stalls
// ------------------
`timescale 1ns/1ps

module alu_checker (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          op_valid_i,
    input  alu_pkg::alu_op_e              op_i,
    input  logic                          op_ready_i,
    input  logic                          res_valid_i,
    input  logic [alu_pkg::CPU_WIDTH-1:0] res_i,
    input  logic                          zero_i,
    input  logic                          less_i,
    output int                            mismatch_count_o,
    output int                            error_count_o,
    output int                            result_count_o,
    output logic                          ready_low_seen_o
);
    import alu_pkg::*;

    localparam int MAX_OPS = 64;
    localparam int COLS    = 6;

    logic [31:0] vectors [MAX_OPS*COLS];
    int          num_ops;
    int          mismatch_count = 0;
    int          error_count    = 0;
    int          result_count   = 0;
    int          accepted       = 0;
    logic        ready_low_seen = 1'b0;
    logic        overfill_seen  = 1'b0;

    assign mismatch_count_o = mismatch_count;
    assign error_count_o    = error_count;
    assign result_count_o   = result_count;
    assign ready_low_seen_o = ready_low_seen;

    initial begin
        for (int i = 0; i < MAX_OPS*COLS; i++) begin
            vectors[i] = 32'hffff_ffff;
        end
        $readmemh("sim/alu_testdata.txt", vectors);
        num_ops = 0;
        while (num_ops < MAX_OPS && vectors[num_ops*COLS] != 32'hffff_ffff) begin
            num_ops++;
        end
    end

    task automatic compare_result();
        logic [31:0] exp_res;
        logic        exp_zero;
        logic        exp_less;
        int          base;
        if (result_count >= num_ops) begin
            error_count++;
            $display("Unexpected result %h after the last expected line", res_i);
        end else begin
            base     = result_count * COLS;
            exp_res  = vectors[base+3];
            exp_zero = vectors[base+4][0];
            exp_less = vectors[base+5][0];
            if (res_i !== exp_res) begin
                mismatch_count++;
                $display("MISMATCH res_o op %0d: got %h expected %h", result_count, res_i,
                         exp_res);
            end
            if (zero_i !== exp_zero) begin
                mismatch_count++;
                $display("MISMATCH zero_o op %0d: got %h expected %h", result_count, zero_i,
                         exp_zero);
            end
            if (less_i !== exp_less) begin
                mismatch_count++;
                $display("MISMATCH less_o op %0d: got %h expected %h", result_count, less_i,
                         exp_less);
            end
        end
        result_count++;
    endtask

    // --------------------
    // Sampled at the rising edge
    // --------------------
    always @(posedge clk) begin
        if (rst_n) begin
            // Input held off while a divide waits
            if (op_valid_i && !op_ready_i &&
                op_i inside {ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU}) begin
                ready_low_seen = 1'b1;
            end
            if (op_valid_i && op_ready_i) begin
                accepted++;
            end
            if (res_valid_i) begin
                compare_result();
            end
            // One op in the core plus a full buffer at most
            if (accepted - result_count > BUF_DEPTH + 1 && !overfill_seen) begin
                overfill_seen = 1'b1;
                error_count++;
                $display("Too many operations in flight: %0d accepted, %0d answered",
                         accepted, result_count);
            end
        end
    end

endmodule

// ==== source/alu_exec_top.sv ====
// ------------------
// ALU subsystem top: issue, command buffer,
// core and divider
// ------------------
`timescale 1ns/1ps

module alu_exec_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          op_valid_i,
    input  alu_pkg::alu_op_e              op_i,
    input  logic [alu_pkg::CPU_WIDTH-1:0] src1_i,
    input  logic [alu_pkg::CPU_WIDTH-1:0] src2_i,
    output logic                          op_ready_o,
    output logic                          res_valid_o,
    output logic [alu_pkg::CPU_WIDTH-1:0] res_o,
    output logic                          zero_o,
    output logic                          less_o
);
    import alu_pkg::*;

    // Issue to buffer
    logic                 push;
    alu_op_e              push_op;
    logic [CPU_WIDTH-1:0] push_src1;
    logic [CPU_WIDTH-1:0] push_src2;

    // Buffer to core
    logic                 buf_valid;
    alu_op_e              buf_op;
    logic [CPU_WIDTH-1:0] buf_src1;
    logic [CPU_WIDTH-1:0] buf_src2;
    logic                 pop;
    logic                 credit_return;

    // Core to divider
    logic                 div_start;
    logic                 div_signed;
    logic                 div_rem_sel;
    logic [CPU_WIDTH-1:0] dividend;
    logic [CPU_WIDTH-1:0] divisor;
    logic                 div_done;
    logic [CPU_WIDTH-1:0] div_result;

    op_issue u_op_issue (
        .clk             (clk),
        .rst_n           (rst_n),
        .op_valid_i      (op_valid_i),
        .op_i            (op_i),
        .src1_i          (src1_i),
        .src2_i          (src2_i),
        .credit_return_i (credit_return),
        .op_ready_o      (op_ready_o),
        .push_o          (push),
        .push_op_o       (push_op),
        .push_src1_o     (push_src1),
        .push_src2_o     (push_src2)
    );

    op_buffer u_op_buffer (
        .clk             (clk),
        .rst_n           (rst_n),
        .push_i          (push),
        .push_op_i       (push_op),
        .push_src1_i     (push_src1),
        .push_src2_i     (push_src2),
        .pop_i           (pop),
        .valid_o         (buf_valid),
        .op_o            (buf_op),
        .src1_o          (buf_src1),
        .src2_o          (buf_src2),
        .credit_return_o (credit_return)
    );

    alu_core u_alu_core (
        .clk           (clk),
        .rst_n         (rst_n),
        .buf_valid_i   (buf_valid),
        .buf_op_i      (buf_op),
        .buf_src1_i    (buf_src1),
        .buf_src2_i    (buf_src2),
        .div_done_i    (div_done),
        .div_result_i  (div_result),
        .pop_o         (pop),
        .div_start_o   (div_start),
        .div_signed_o  (div_signed),
        .div_rem_sel_o (div_rem_sel),
        .dividend_o    (dividend),
        .divisor_o     (divisor),
        .res_valid_o   (res_valid_o),
        .res_o         (res_o),
        .zero_o        (zero_o),
        .less_o        (less_o)
    );

    div_unit u_div_unit (
        .clk        (clk),
        .rst_n      (rst_n),
        .start_i    (div_start),
        .signed_i   (div_signed),
        .rem_i      (div_rem_sel),
        .dividend_i (dividend),
        .divisor_i  (divisor),
        .done_o     (div_done),
        .result_o   (div_result)
    );

endmodule

// ==== source/alu_core.sv ====
// ------------------
// ALU core FSM: pops one operation at a time
// Single cycle ops, registered multiply, iterative divide
// ------------------
`timescale 1ns/1ps

module alu_core (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          buf_valid_i,
    input  alu_pkg::alu_op_e              buf_op_i,
    input  logic [alu_pkg::CPU_WIDTH-1:0] buf_src1_i,
    input  logic [alu_pkg::CPU_WIDTH-1:0] buf_src2_i,
    input  logic                          div_done_i,
    input  logic [alu_pkg::CPU_WIDTH-1:0] div_result_i,
    output logic                          pop_o,
    output logic                          div_start_o,
    output logic                          div_signed_o,
    output logic                          div_rem_sel_o,
    output logic [alu_pkg::CPU_WIDTH-1:0] dividend_o,
    output logic [alu_pkg::CPU_WIDTH-1:0] divisor_o,
    output logic                          res_valid_o,
    output logic [alu_pkg::CPU_WIDTH-1:0] res_o,
    output logic                          zero_o,
    output logic                          less_o
);
    import alu_pkg::*;

    core_state_e                 state_q;
    core_state_e                 state_d;
    alu_op_e                     op_q;
    logic [CPU_WIDTH-1:0]        src1_q;
    logic [CPU_WIDTH-1:0]        src2_q;
    logic [CPU_WIDTH-1:0]        mul_a_q;
    logic [CPU_WIDTH-1:0]        mul_b_q;
    logic                        mul_neg_q;
    logic [CPU_DOUBLE_WIDTH-1:0] product;
    logic [CPU_DOUBLE_WIDTH-1:0] product_fix;
    logic [CPU_WIDTH-1:0]        simple_res;
    logic [CPU_WIDTH-1:0]        res_d;
    logic                        is_mul;
    logic                        is_div;
    logic                        res_fire;
    logic                        slt;
    logic                        sltu;
    logic [4:0]                  shamt;

    assign is_mul = op_q inside {ALU_MUL, ALU_MULH, ALU_MULHU, ALU_MULHSU};
    assign is_div = op_q inside {ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU};
    assign shamt  = src2_q[4:0];
    assign slt    = $signed(src1_q) < $signed(src2_q);
    assign sltu   = src1_q < src2_q;

    // Only take a new op when nothing is in flight
    assign pop_o = (state_q == ST_IDLE) && buf_valid_i;

    // Divider request
    assign div_start_o   = (state_q == ST_EXEC) && is_div;
    assign div_signed_o  = (op_q == ALU_DIV) || (op_q == ALU_REM);
    assign div_rem_sel_o = (op_q == ALU_REM) || (op_q == ALU_REMU);
    assign dividend_o    = src1_q;
    assign divisor_o     = src2_q;

    // ------------------
    // Single cycle ops
    // ------------------
    always_comb begin
        case (op_q)
            ALU_ADD:  simple_res = src1_q + src2_q;
            ALU_SUB:  simple_res = src1_q - src2_q;
            ALU_XOR:  simple_res = src1_q ^ src2_q;
            ALU_OR:   simple_res = src1_q | src2_q;
            ALU_AND:  simple_res = src1_q & src2_q;
            ALU_SLL:  simple_res = src1_q << shamt;
            ALU_SRL:  simple_res = src1_q >> shamt;
            ALU_SRA:  simple_res = $unsigned($signed(src1_q) >>> shamt);
            ALU_SLT:  simple_res = {{(CPU_WIDTH-1){1'b0}}, slt};
            ALU_SLTU: simple_res = {{(CPU_WIDTH-1){1'b0}}, sltu};
            default:  simple_res = '0;
        endcase
    end

    // Product of the registered magnitudes, sign restored afterwards
    assign product     = mul_a_q * mul_b_q;
    assign product_fix = mul_neg_q ? (~product + 1'b1) : product;

    always_comb begin
        state_d  = state_q;
        res_fire = 1'b0;
        res_d    = simple_res;
        case (state_q)
            ST_IDLE: if (buf_valid_i) state_d = ST_EXEC;
            ST_EXEC: begin
                if (is_mul) begin
                    state_d = ST_MUL;
                end else if (is_div) begin
                    state_d = ST_DIV;
                end else begin
                    state_d  = ST_IDLE;
                    res_fire = 1'b1;
                end
            end
            ST_MUL: begin
                state_d  = ST_IDLE;
                res_fire = 1'b1;
                res_d    = (op_q == ALU_MUL) ? product_fix[CPU_WIDTH-1:0]
                                             : product_fix[CPU_DOUBLE_WIDTH-1:CPU_WIDTH];
            end
            ST_DIV: begin
                res_d = div_result_i;
                if (div_done_i) begin
                    state_d  = ST_IDLE;
                    res_fire = 1'b1;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q     <= ST_IDLE;
            res_valid_o <= 1'b0;
        end else begin
            state_q     <= state_d;
            res_valid_o <= res_fire;
        end
    end

    // ------------------
    // Operands and result payload
    // ------------------
    always_ff @(posedge clk) begin
        if (pop_o) begin
            op_q   <= buf_op_i;
            src1_q <= buf_src1_i;
            src2_q <= buf_src2_i;
        end
        if (state_q == ST_EXEC && is_mul) begin
            // MUL and MULHU multiply raw operands
            mul_a_q   <= src1_q;
            mul_b_q   <= src2_q;
            mul_neg_q <= 1'b0;
            if (op_q == ALU_MULH || op_q == ALU_MULHSU) begin
                mul_a_q   <= src1_q[CPU_WIDTH-1] ? (~src1_q + 1'b1) : src1_q;
                mul_neg_q <= src1_q[CPU_WIDTH-1];
            end
            if (op_q == ALU_MULH) begin
                mul_b_q   <= src2_q[CPU_WIDTH-1] ? (~src2_q + 1'b1) : src2_q;
                mul_neg_q <= src1_q[CPU_WIDTH-1] ^ src2_q[CPU_WIDTH-1];
            end
        end
        if (res_fire) begin
            res_o  <= res_d;
            zero_o <= (state_q == ST_EXEC) && (op_q == ALU_SUB) && (simple_res == '0);
            less_o <= (state_q == ST_EXEC) && ((op_q == ALU_SLT && slt) ||
                                               (op_q == ALU_SLTU && sltu));
        end
    end

endmodule

// ==== source/div_unit.sv ====
// ------------------
// Restoring radix-2 divider, 32 steps
// Signed and unsigned quotient or remainder
// ------------------
`timescale 1ns/1ps

module div_unit (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          start_i,
    input  logic                          signed_i,
    input  logic                          rem_i,
    input  logic [alu_pkg::CPU_WIDTH-1:0] dividend_i,
    input  logic [alu_pkg::CPU_WIDTH-1:0] divisor_i,
    output logic                          done_o,
    output logic [alu_pkg::CPU_WIDTH-1:0] result_o
);
    import alu_pkg::*;

    logic                 busy_q;
    logic [5:0]           step_q;
    logic [CPU_WIDTH-1:0] quo_q;
    logic [CPU_WIDTH-1:0] rem_q;
    logic [CPU_WIDTH-1:0] dvs_q;
    logic                 quo_neg_q;
    logic                 rem_neg_q;
    logic                 rem_sel_q;
    logic                 dvs_zero_q;
    logic [CPU_WIDTH:0]   shifted;
    logic [CPU_WIDTH:0]   trial;
    logic                 a_neg;
    logic                 b_neg;

    assign a_neg = signed_i && dividend_i[CPU_WIDTH-1];
    assign b_neg = signed_i && divisor_i[CPU_WIDTH-1];

    // Bring down next dividend bit and try a subtract
    assign shifted = {rem_q, quo_q[CPU_WIDTH-1]};
    assign trial   = shifted - {1'b0, dvs_q};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            step_q <= '0;
            done_o <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (start_i && !busy_q) begin
                busy_q <= 1'b1;
                step_q <= '0;
            end else if (busy_q) begin
                step_q <= step_q + 1'b1;
                if (step_q == 6'(CPU_WIDTH)) begin
                    busy_q <= 1'b0;
                    done_o <= 1'b1;
                end
            end
        end
    end

    // ------------------
    // Data path
    // ------------------
    always_ff @(posedge clk) begin
        if (start_i && !busy_q) begin
            quo_q      <= a_neg ? (~dividend_i + 1'b1) : dividend_i;
            dvs_q      <= b_neg ? (~divisor_i + 1'b1) : divisor_i;
            rem_q      <= '0;
            quo_neg_q  <= a_neg ^ b_neg;
            rem_neg_q  <= a_neg;
            rem_sel_q  <= rem_i;
            dvs_zero_q <= (divisor_i == '0);
        end else if (busy_q && step_q != 6'(CPU_WIDTH)) begin
            if (!trial[CPU_WIDTH]) begin
                rem_q <= trial[CPU_WIDTH-1:0];
                quo_q <= {quo_q[CPU_WIDTH-2:0], 1'b1};
            end else begin
                rem_q <= shifted[CPU_WIDTH-1:0];
                quo_q <= {quo_q[CPU_WIDTH-2:0], 1'b0};
            end
        end else if (busy_q) begin
            // Sign fix, the overflow case falls out of the magnitudes
            if (rem_sel_q) begin
                result_o <= rem_neg_q ? (~rem_q + 1'b1) : rem_q;
            end else if (dvs_zero_q) begin
                result_o <= '1;
            end else begin
                result_o <= quo_neg_q ? (~quo_q + 1'b1) : quo_q;
            end
        end
    end

endmodule

// ==== source/op_buffer.sv ====
// ------------------
// Command FIFO between issue stage and core
// Returns one credit per pop
// ------------------
`timescale 1ns/1ps

module op_buffer (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          push_i,
    input  alu_pkg::alu_op_e              push_op_i,
    input  logic [alu_pkg::CPU_WIDTH-1:0] push_src1_i,
    input  logic [alu_pkg::CPU_WIDTH-1:0] push_src2_i,
    input  logic                          pop_i,
    output logic                          valid_o,
    output alu_pkg::alu_op_e              op_o,
    output logic [alu_pkg::CPU_WIDTH-1:0] src1_o,
    output logic [alu_pkg::CPU_WIDTH-1:0] src2_o,
    output logic                          credit_return_o
);
    import alu_pkg::*;

    alu_op_e                 op_mem   [BUF_DEPTH];
    logic [CPU_WIDTH-1:0]    src1_mem [BUF_DEPTH];
    logic [CPU_WIDTH-1:0]    src2_mem [BUF_DEPTH];

    logic [BUF_PTR_WIDTH-1:0] wr_ptr_q;
    logic [BUF_PTR_WIDTH-1:0] rd_ptr_q;
    logic [CREDIT_WIDTH-1:0]  count_q;

    // Head entry seen directly by the core
    assign valid_o = (count_q != '0);
    assign op_o    = op_mem[rd_ptr_q];
    assign src1_o  = src1_mem[rd_ptr_q];
    assign src2_o  = src2_mem[rd_ptr_q];

    always_ff @(posedge clk) begin
        if (push_i) begin
            op_mem[wr_ptr_q]   <= push_op_i;
            src1_mem[wr_ptr_q] <= push_src1_i;
            src2_mem[wr_ptr_q] <= push_src2_i;
        end
    end

    // ------------------
    // Pointers and occupancy
    // ------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q        <= '0;
            rd_ptr_q        <= '0;
            count_q         <= '0;
            credit_return_o <= 1'b0;
        end else begin
            if (push_i) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop_i)  rd_ptr_q <= rd_ptr_q + 1'b1;
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
            // Freed slot goes back to the issue stage
            credit_return_o <= pop_i;
        end
    end

endmodule

// ==== source/op_issue.sv ====
// ------------------
// Issue stage with credit counter
// Accepts operations and forwards them one cycle later
// ------------------
`timescale 1ns/1ps

module op_issue (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          op_valid_i,
    input  alu_pkg::alu_op_e              op_i,
    input  logic [alu_pkg::CPU_WIDTH-1:0] src1_i,
    input  logic [alu_pkg::CPU_WIDTH-1:0] src2_i,
    input  logic                          credit_return_i,
    output logic                          op_ready_o,
    output logic                          push_o,
    output alu_pkg::alu_op_e              push_op_o,
    output logic [alu_pkg::CPU_WIDTH-1:0] push_src1_o,
    output logic [alu_pkg::CPU_WIDTH-1:0] push_src2_o
);
    import alu_pkg::*;

    logic [CREDIT_WIDTH-1:0] credits_q;
    logic                    accept;

    // One free buffer slot per credit
    assign op_ready_o = (credits_q != '0);
    assign accept     = op_valid_i && op_ready_o;

    // ------------------
    // Credit counter
    // ------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits_q <= CREDIT_WIDTH'(BUF_DEPTH);
        end else begin
            case ({accept, credit_return_i})
                2'b10:   credits_q <= credits_q - 1'b1;
                2'b01:   credits_q <= credits_q + 1'b1;
                default: credits_q <= credits_q;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            push_o <= 1'b0;
        end else begin
            push_o <= accept;
        end
    end

    // Operation payload, captured on acceptance
    always_ff @(posedge clk) begin
        if (accept) begin
            push_op_o   <= op_i;
            push_src1_o <= src1_i;
            push_src2_o <= src2_i;
        end
    end

endmodule

// ==== source/alu_pkg.sv ====
// ------------------
// Shared widths and sizes of the ALU subsystem
// Operation and core state encodings
// ------------------
package alu_pkg;

    // Data path widths
    localparam int CPU_WIDTH        = 32;
    localparam int CPU_DOUBLE_WIDTH = 64;
    localparam int ALU_OP_WIDTH     = 5;

    // Command buffer and credit sizing
    localparam int BUF_DEPTH     = 4;
    localparam int BUF_PTR_WIDTH = $clog2(BUF_DEPTH);
    localparam int CREDIT_WIDTH  = 3;

    typedef enum logic [ALU_OP_WIDTH-1:0] {
        ALU_ADD    = 5'h00,
        ALU_SUB    = 5'h01,
        ALU_XOR    = 5'h02,
        ALU_OR     = 5'h03,
        ALU_AND    = 5'h04,
        ALU_SLL    = 5'h05,
        ALU_SRL    = 5'h06,
        ALU_SRA    = 5'h07,
        ALU_SLT    = 5'h08,
        ALU_SLTU   = 5'h09,
        ALU_MUL    = 5'h0a,
        ALU_MULH   = 5'h0b,
        ALU_MULHU  = 5'h0c,
        ALU_MULHSU = 5'h0d,
        ALU_DIV    = 5'h0e,
        ALU_DIVU   = 5'h0f,
        ALU_REM    = 5'h10,
        ALU_REMU   = 5'h11
    } alu_op_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_EXEC,
        ST_MUL,
        ST_DIV
    } core_state_e;

endpackage
